// ==== src/swap_mem_config.svh ====
// ---------------------------------------------------------
// Block-swap memory configuration
// ---------------------------------------------------------

`ifndef SWAP_MEM_CONFIG_SVH
`define SWAP_MEM_CONFIG_SVH

// Bus widths
`define SM_ADDR_WIDTH 32
`define SM_DATA_WIDTH 32

// Block geometry, 256-byte blocks
`define SM_OFFSET_BITS 8
// Address bits 28..8, anything above is out of range
`define SM_BLOCK_BITS 21

// Physical slots, top slot bit picks the bank
`define SM_SLOT_BITS 2
`define SM_NUM_BANKS 2
`define SM_BANK_WORDS 128

// Request buffering between blocker and banks
`define SM_FIFO_DEPTH 2

// Read data returned with err set
`define SM_ERR_DATA 32'hBADCAB1E

`endif

// ==== src/obi_pkg.sv ====
// ---------------------------------------------------------
// OBI bus types
// ---------------------------------------------------------

`default_nettype none

`include "swap_mem_config.svh"

package obi_pkg;

  // Operation carried by a request, we=1 is a write
  typedef enum logic {
    OBI_READ  = 1'b0,
    OBI_WRITE = 1'b1
  } obi_op_e;

  // Byte address
  typedef logic [`SM_ADDR_WIDTH-1:0] obi_addr_t;

  // Read and write data
  typedef logic [`SM_DATA_WIDTH-1:0] obi_data_t;

  // One enable per data byte
  typedef logic [`SM_DATA_WIDTH/8-1:0] obi_be_t;

endpackage

`default_nettype wire

// ==== src/swap_pkg.sv ====
// ---------------------------------------------------------
// Block-swap types
// ---------------------------------------------------------

`default_nettype none

`include "swap_mem_config.svh"

package swap_pkg;

  typedef logic [`SM_BLOCK_BITS-1:0] block_num_t;
  typedef logic [`SM_SLOT_BITS-1:0]  slot_idx_t;

  // Slot index followed by the word inside the block
  typedef logic [`SM_SLOT_BITS+`SM_OFFSET_BITS-$clog2(`SM_DATA_WIDTH/8)-1:0] phys_word_t;

  // One remapped request on its way to the banks
  typedef struct packed {
    obi_pkg::obi_op_e   op;
    phys_word_t         phys;
    obi_pkg::obi_be_t   be;
    obi_pkg::obi_data_t wdata;
    logic               err;
  } mem_entry_t;

  typedef enum logic [1:0] {
    BLK_IDLE,
    BLK_LOOKUP,
    BLK_ISSUE
  } blk_state_e;

endpackage

`default_nettype wire

// ==== src/mem_req_if.sv ====
// ---------------------------------------------------------
// Remapped request channel
// ---------------------------------------------------------

`timescale 1ns/1ps
`default_nettype none

// Valid/ready channel, transfer on any edge with both high.
// Entry stays stable while valid is high and ready is low.
interface mem_req_if;
  import swap_pkg::*;

  logic       valid;
  logic       ready;
  mem_entry_t entry;

  // Upstream side, offers entries
  modport producer (
    output valid,
    output entry,
    input  ready
  );

  // Downstream side, accepts entries
  modport consumer (
    input  valid,
    input  entry,
    output ready
  );

endinterface

`default_nettype wire

// ==== src/req_blocker.sv ====
// ---------------------------------------------------------
// Request blocker and block remap
// ---------------------------------------------------------

`timescale 1ns/1ps
`default_nettype none

`include "swap_mem_config.svh"

module req_blocker (
  input  logic                 clk_i,
  input  logic                 arst_n_i,

  input  logic                 req_i,
  input  logic                 we_i,
  input  obi_pkg::obi_addr_t   addr_i,
  input  obi_pkg::obi_be_t     be_i,
  input  obi_pkg::obi_data_t   wdata_i,
  output logic                 gnt_o,

  output swap_pkg::block_num_t swap_addr_o,
  output logic                 swap_valid_o,
  input  swap_pkg::slot_idx_t  slot_idx_i,
  input  logic                 block_i,

  mem_req_if.producer          out_o
);
  import obi_pkg::*;
  import swap_pkg::*;

  localparam int unsigned BYTE_BITS = $clog2(`SM_DATA_WIDTH / 8);
  localparam int unsigned WORD_BITS = `SM_OFFSET_BITS - BYTE_BITS;
  localparam int unsigned RANGE_LSB = `SM_OFFSET_BITS + `SM_BLOCK_BITS;

  blk_state_e           state_q, state_d;
  block_num_t           block_q;
  slot_idx_t            slot_q;
  logic [WORD_BITS-1:0] word_q;
  logic                 we_q;
  obi_be_t              be_q;
  obi_data_t            wdata_q;
  logic                 err_q;
  logic                 out_of_range;

  // Any set bit above the block number falls outside the swap region
  assign out_of_range = |addr_i[`SM_ADDR_WIDTH-1:RANGE_LSB];

  always_comb begin
    state_d = state_q;
    unique case (state_q)
      BLK_IDLE:   if (req_i) state_d = out_of_range ? BLK_ISSUE : BLK_LOOKUP;
      BLK_LOOKUP: if (!block_i) state_d = BLK_ISSUE;
      BLK_ISSUE:  if (out_o.ready) state_d = BLK_IDLE;
      default:    state_d = BLK_IDLE;
    endcase
  end

  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      state_q <= BLK_IDLE;
    end else begin
      state_q <= state_d;
    end
  end

  // Request capture, then the slot once the table lets go
  always_ff @(posedge clk_i) begin
    if (state_q == BLK_IDLE && req_i) begin
      block_q <= addr_i[RANGE_LSB-1:`SM_OFFSET_BITS];
      word_q  <= addr_i[`SM_OFFSET_BITS-1:BYTE_BITS];
      we_q    <= we_i;
      be_q    <= be_i;
      wdata_q <= wdata_i;
      err_q   <= out_of_range;
      slot_q  <= '0;
    end else if (state_q == BLK_LOOKUP && !block_i) begin
      slot_q  <= slot_idx_i;
    end
  end

  // Swap table lookup
  assign swap_valid_o = (state_q == BLK_LOOKUP);
  assign swap_addr_o  = block_q;

  always_comb begin
    out_o.valid       = (state_q == BLK_ISSUE);
    out_o.entry.op    = we_q ? OBI_WRITE : OBI_READ;
    out_o.entry.phys  = {slot_q, word_q};
    out_o.entry.be    = be_q;
    out_o.entry.wdata = wdata_q;
    out_o.entry.err   = err_q;
  end

  // Grant in the cycle the FIFO takes the entry
  assign gnt_o = out_o.valid & out_o.ready;

endmodule

`default_nettype wire

// ==== src/req_fifo.sv ====
// ---------------------------------------------------------
// Request FIFO
// ---------------------------------------------------------

`timescale 1ns/1ps
`default_nettype none

`include "swap_mem_config.svh"

module req_fifo (
  input  logic        clk_i,
  input  logic        arst_n_i,
  mem_req_if.consumer in_i,
  mem_req_if.producer out_o
);
  import swap_pkg::*;

  localparam int unsigned DEPTH = `SM_FIFO_DEPTH;
  localparam int unsigned PTR_W = (DEPTH > 1) ? $clog2(DEPTH) : 1;
  localparam int unsigned CNT_W = $clog2(DEPTH + 1);

  mem_entry_t         mem_q [DEPTH];
  logic [PTR_W-1:0]   wr_ptr_q;
  logic [PTR_W-1:0]   rd_ptr_q;
  logic [CNT_W-1:0]   count_q;
  logic               push;
  logic               pop;

  assign in_i.ready  = (count_q != CNT_W'(DEPTH));
  assign out_o.valid = (count_q != '0);
  assign out_o.entry = mem_q[rd_ptr_q];

  assign push = in_i.valid & in_i.ready;
  assign pop  = out_o.valid & out_o.ready;

  // Pointers and fill level
  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      wr_ptr_q <= '0;
      rd_ptr_q <= '0;
      count_q  <= '0;
    end else begin
      if (push) begin
        wr_ptr_q <= (wr_ptr_q == PTR_W'(DEPTH - 1)) ? '0 : wr_ptr_q + 1'b1;
      end
      if (pop) begin
        rd_ptr_q <= (rd_ptr_q == PTR_W'(DEPTH - 1)) ? '0 : rd_ptr_q + 1'b1;
      end
      // Simultaneous push and pop leaves the level alone
      if (push && !pop) begin
        count_q <= count_q + 1'b1;
      end else if (pop && !push) begin
        count_q <= count_q - 1'b1;
      end
    end
  end

  // Entry storage
  always_ff @(posedge clk_i) begin
    if (push) begin
      mem_q[wr_ptr_q] <= in_i.entry;
    end
  end

endmodule

`default_nettype wire

// ==== src/sram_bank_array.sv ====
// ---------------------------------------------------------
// Banked SRAM with error response
// ---------------------------------------------------------

`timescale 1ns/1ps
`default_nettype none

`include "swap_mem_config.svh"

module sram_bank_array (
  input  logic               clk_i,
  input  logic               arst_n_i,
  mem_req_if.consumer        in_i,
  output logic               rvalid_o,
  output obi_pkg::obi_data_t rdata_o,
  output logic               err_o
);
  import obi_pkg::*;
  import swap_pkg::*;

  localparam int unsigned PHYS_W  = $bits(phys_word_t);
  localparam int unsigned SEL_W   = (`SM_NUM_BANKS > 1) ? $clog2(`SM_NUM_BANKS) : 1;
  localparam int unsigned ADDR_W  = $clog2(`SM_BANK_WORDS);
  localparam int unsigned BYTES   = `SM_DATA_WIDTH / 8;

  logic [SEL_W-1:0]  bank_sel;
  logic [ADDR_W-1:0] bank_addr;
  logic              access;
  logic              is_write;
  obi_data_t         bank_rdata [`SM_NUM_BANKS];
  logic [SEL_W-1:0]  sel_q;
  logic              rd_q;
  logic              err_q;

  // Single-cycle SRAM, never back-pressures
  assign in_i.ready = 1'b1;

  // Top slot bit picks the bank, the rest is the word inside it
  assign bank_sel  = in_i.entry.phys[PHYS_W-1 -: SEL_W];
  assign bank_addr = in_i.entry.phys[ADDR_W-1:0];
  assign access    = in_i.valid & ~in_i.entry.err;
  assign is_write  = (in_i.entry.op == OBI_WRITE);

  for (genvar b = 0; b < `SM_NUM_BANKS; b++) begin : gen_bank
    obi_data_t mem_q [`SM_BANK_WORDS];
    obi_data_t rdata_q;
    logic      bank_req;

    assign bank_req      = access & (bank_sel == SEL_W'(b));
    assign bank_rdata[b] = rdata_q;

    always_ff @(posedge clk_i) begin
      if (bank_req && is_write) begin
        for (int i = 0; i < BYTES; i++) begin
          if (in_i.entry.be[i]) begin
            mem_q[bank_addr][i*8 +: 8] <= in_i.entry.wdata[i*8 +: 8];
          end
        end
      end else if (bank_req) begin
        rdata_q <= mem_q[bank_addr];
      end
    end
  end

  // Response stage, one cycle after acceptance
  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      rvalid_o <= 1'b0;
      sel_q    <= '0;
      rd_q     <= 1'b0;
      err_q    <= 1'b0;
    end else begin
      rvalid_o <= in_i.valid;
      sel_q    <= bank_sel;
      rd_q     <= ~is_write;
      err_q    <= in_i.entry.err;
    end
  end

  // Write responses carry zero data
  assign err_o   = err_q;
  assign rdata_o = err_q ? obi_data_t'(`SM_ERR_DATA) :
                   rd_q  ? bank_rdata[sel_q] : '0;

endmodule

`default_nettype wire

// ==== src/swap_mem_top.sv ====
// ---------------------------------------------------------
// Block-swap memory path top level
// ---------------------------------------------------------

`timescale 1ns/1ps
`default_nettype none

module swap_mem_top (
  input  logic                 clk_i,
  input  logic                 arst_n_i,

  // Manager request channel
  input  logic                 req_i,
  input  logic                 we_i,
  input  obi_pkg::obi_addr_t   addr_i,
  input  obi_pkg::obi_be_t     be_i,
  input  obi_pkg::obi_data_t   wdata_i,
  output logic                 gnt_o,

  // Manager response channel
  output logic                 rvalid_o,
  output obi_pkg::obi_data_t   rdata_o,
  output logic                 err_o,

  // Swap table
  output swap_pkg::block_num_t swap_addr_o,
  output logic                 swap_valid_o,
  input  swap_pkg::slot_idx_t  slot_idx_i,
  input  logic                 block_i
);

  mem_req_if blk2fifo ();
  mem_req_if fifo2bank ();

  req_blocker i_req_blocker (
    .clk_i,
    .arst_n_i,
    .req_i,
    .we_i,
    .addr_i,
    .be_i,
    .wdata_i,
    .gnt_o,
    .swap_addr_o,
    .swap_valid_o,
    .slot_idx_i,
    .block_i,
    .out_o        ( blk2fifo.producer )
  );

  req_fifo i_req_fifo (
    .clk_i,
    .arst_n_i,
    .in_i         ( blk2fifo.consumer  ),
    .out_o        ( fifo2bank.producer )
  );

  sram_bank_array i_sram_bank_array (
    .clk_i,
    .arst_n_i,
    .in_i         ( fifo2bank.consumer ),
    .rvalid_o,
    .rdata_o,
    .err_o
  );

endmodule

`default_nettype wire

// ==== tests/tb_swap_mem.sv ====
// ---------------------------------------------------------
// Block-swap memory testbench
// ---------------------------------------------------------

`timescale 1ns/1ps
`default_nettype none

module tb_swap_mem;

  localparam int unsigned GNT_TIMEOUT   = 64;
  localparam int unsigned DRAIN_TIMEOUT = 32;
  localparam string       PATTERN_FILE  = "tests/swap_mem_patterns.txt";

  logic        clk;
  logic        arst_n;
  logic        req;
  logic        we;
  logic [31:0] addr;
  logic [3:0]  be;
  logic [31:0] wdata;
  logic        gnt;
  logic        rvalid;
  logic [31:0] rdata;
  logic        err;
  logic [20:0] swap_addr;
  logic        swap_valid;
  logic [1:0]  slot_idx;
  logic        block;

  integer      seed;
  logic [32:0] expected_q [$];
  int unsigned grant_count;
  int unsigned resp_count;
  int unsigned stall_cycles;
  logic        lookup_stalled;
  logic        cur_oor;
  logic [20:0] cur_block;

  swap_mem_top DUT (
    .clk_i        ( clk        ),
    .arst_n_i     ( arst_n     ),
    .req_i        ( req        ),
    .we_i         ( we         ),
    .addr_i       ( addr       ),
    .be_i         ( be         ),
    .wdata_i      ( wdata      ),
    .gnt_o        ( gnt        ),
    .rvalid_o     ( rvalid     ),
    .rdata_o      ( rdata      ),
    .err_o        ( err        ),
    .swap_addr_o  ( swap_addr  ),
    .swap_valid_o ( swap_valid ),
    .slot_idx_i   ( slot_idx   ),
    .block_i      ( block      )
  );

  always #4 clk = ~clk;

  // ---------------------------------------------------------
  // Swap table model
  // ---------------------------------------------------------
  // Block number modulo four picks the slot
  assign slot_idx = swap_addr[1:0];

  // Roughly three cycles in eight are blocked
  always @(posedge clk) begin
    #1;
    block = (($random(seed) & 7) < 3);
  end

  task automatic fail_stop(input string reason);
    $display("%s", reason);
    $display("** FAIL **");
    $fatal(1, "simulation stopped on error");
  endtask

  task automatic compare_value(input logic [31:0] got, input logic [31:0] want,
                               input string what);
    if (got !== want) begin
      fail_stop($sformatf("[FAIL] %0t ns: %s got %08h, expected %08h",
                          $time, what, got, want));
    end
  endtask

  task automatic check_idle_outputs(input string phase);
    compare_value(32'(gnt), 32'd0, {"gnt_o ", phase});
    compare_value(32'(rvalid), 32'd0, {"rvalid_o ", phase});
    compare_value(32'(swap_valid), 32'd0, {"swap_valid_o ", phase});
  endtask

  task automatic wait_grant(input int unsigned line_no);
    int unsigned cycles;
    cycles = 0;
    @(negedge clk);
    while (!gnt && cycles < GNT_TIMEOUT) begin
      @(negedge clk);
      cycles++;
    end
    if (!gnt) begin
      fail_stop($sformatf("Timeout waiting for gnt_o on pattern line %0d", line_no));
    end
  endtask

  // ---------------------------------------------------------
  // Response and lookup monitor
  // ---------------------------------------------------------
  always @(negedge clk) begin : response_monitor
    logic [32:0] exp_entry;
    // A blocked lookup must still be pending one cycle later
    if (lookup_stalled) begin
      compare_value(32'(swap_valid), 32'd1, "swap_valid_o after a blocked lookup cycle");
    end
    lookup_stalled = swap_valid & block;
    if (swap_valid) begin
      compare_value(32'(cur_oor), 32'd0, "swap_valid_o for out-of-range request");
      compare_value(32'(swap_addr), 32'(cur_block), "swap_addr_o block number");
      if (block) begin
        stall_cycles++;
        compare_value(32'(gnt), 32'd0, "gnt_o while block_i high");
      end
    end
    if (gnt) begin
      grant_count++;
    end
    if (rvalid) begin
      resp_count++;
      if (expected_q.size() == 0) begin
        fail_stop("Response arrived with no granted request outstanding");
      end else begin
        exp_entry = expected_q.pop_front();
        compare_value(rdata, exp_entry[31:0], "rdata_o");
        compare_value(32'(err), 32'(exp_entry[32]), "err_o");
      end
    end
  end

  // ---------------------------------------------------------
  // Stimulus from the pattern file
  // ---------------------------------------------------------
  initial begin : stimulus
    int               fd;
    int               code;
    int unsigned      line_no;
    int unsigned      req_total;
    int unsigned      cycles;
    logic [8*160-1:0] line;
    logic [31:0]      f_we;
    logic [31:0]      f_addr;
    logic [31:0]      f_be;
    logic [31:0]      f_wdata;
    logic [31:0]      f_rdata;
    logic [31:0]      f_err;

    clk            = 1'b0;
    arst_n         = 1'b0;
    req            = 1'b0;
    we             = 1'b0;
    addr           = '0;
    be             = '0;
    wdata          = '0;
    block          = 1'b0;
    seed           = 7268;
    grant_count    = 0;
    resp_count     = 0;
    stall_cycles   = 0;
    lookup_stalled = 1'b0;
    cur_oor        = 1'b0;
    cur_block      = '0;
    line_no        = 0;
    req_total      = 0;

    fd = $fopen(PATTERN_FILE, "r");
    if (fd == 0) begin
      fail_stop("Cannot open the pattern file tests/swap_mem_patterns.txt");
    end

    for (int i = 0; i < 8; i++) begin
      @(negedge clk);
      check_idle_outputs("during reset");
    end
    @(posedge clk);
    #1;
    arst_n = 1'b1;
    @(negedge clk);
    check_idle_outputs("after reset");

    // req stays high from the first request to the last grant
    @(posedge clk);
    #1;
    while (!$feof(fd)) begin
      line = '0;
      code = $fgets(line, fd);
      line_no++;
      code = $sscanf(line, "%h %h %h %h %h %h",
                     f_we, f_addr, f_be, f_wdata, f_rdata, f_err);
      if (code == 6) begin
        req       = 1'b1;
        we        = f_we[0];
        addr      = f_addr;
        be        = f_be[3:0];
        wdata     = f_wdata;
        cur_oor   = (f_addr[31:29] != 3'b000);
        cur_block = f_addr[28:8];
        wait_grant(line_no);
        expected_q.push_back({f_err[0], f_rdata});
        req_total++;
        @(posedge clk);
        #1;
      end
    end
    req   = 1'b0;
    we    = 1'b0;
    addr  = '0;
    be    = '0;
    wdata = '0;
    $fclose(fd);

    cycles = 0;
    while (resp_count != req_total && cycles < DRAIN_TIMEOUT) begin
      @(posedge clk);
      cycles++;
    end
    if (resp_count != req_total) begin
      fail_stop("Timeout waiting for the remaining rvalid_o responses");
    end

    compare_value(32'(resp_count), 32'(grant_count), "rvalid_o pulses versus grants");
    compare_value(32'(grant_count), 32'(req_total), "grants versus pattern requests");
    compare_value(32'(stall_cycles != 0), 32'd1, "lookup stalls under block_i");
    $display("** PASS **");
    $finish;
  end

endmodule

`default_nettype wire

// ==== project.f ====
+incdir+src
src/obi_pkg.sv
src/swap_pkg.sv
src/mem_req_if.sv
src/req_blocker.sv
src/req_fifo.sv
src/sram_bank_array.sv
src/swap_mem_top.sv
tests/tb_swap_mem.sv

// ==== Makefile ====
# Verilator build and run for the block-swap memory path

VERILATOR ?= verilator
TOP       ?= tb_swap_mem
FILELIST  ?= project.f
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --binary --timing -j 0
PASS_MSG  ?= ** PASS **

SOURCES := $(shell grep -v '^+' $(FILELIST))
HEADERS := $(wildcard src/*.svh)
BIN     := $(OBJ_DIR)/V$(TOP)

.PHONY: all run clean

all: $(BIN)

$(BIN): $(SOURCES) $(HEADERS) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR) -o V$(TOP)

run: $(BIN)
	@out="$$(./$(BIN))"; echo "$$out"; echo "$$out" | grep -qF '$(PASS_MSG)'

clean:
	rm -rf $(OBJ_DIR)

// ==== tests/swap_mem_patterns.txt ====
# Columns: we addr be wdata exp_rdata exp_err, all hex
# we=1 is a write; write responses return zero data
1 00000000 f 11223344 00000000 0
0 00000000 0 00000000 11223344 0
1 00000000 5 aabbccdd 00000000 0
0 00000000 0 00000000 11bb33dd 0
1 00000104 f 01020304 00000000 0
1 00000208 f 05060708 00000000 0
1 0000030c f 090a0b0c 00000000 0
1 00000404 f cafef00d 00000000 0
0 00000004 0 00000000 cafef00d 0
0 00000104 0 00000000 01020304 0
0 00000208 0 00000000 05060708 0
1 00000504 a 5500aa00 00000000 0
0 00000104 0 00000000 5502aa04 0
0 00000608 0 00000000 05060708 0
0 0000070c 0 00000000 090a0b0c 0
0 10000400 0 00000000 11bb33dd 0
0 20000000 0 00000000 badcab1e 1
1 20000000 f ffffffff badcab1e 1
1 e0000004 f deadbeef badcab1e 1
1 20000104 f 00000000 badcab1e 1
0 80000104 0 00000000 badcab1e 1
0 00000000 0 00000000 11bb33dd 0
0 00000004 0 00000000 cafef00d 0
0 00000104 0 00000000 5502aa04 0
1 00000208 3 0000beef 00000000 0
0 00000208 0 00000000 0506beef 0
1 1ffffffc f 87654321 00000000 0
0 000003fc 0 00000000 87654321 0
